// File: isa_pkg.sv
/* Operation encoding, datapath and register-file widths,
   and the zero word used across the backend. */

package isa_pkg;

    localparam int XLEN       = 64;
    localparam int PC_W       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [XLEN-1:0] ZERO_WORD = '0;

    // operations understood by the execute and memory stages.
    typedef enum logic [3:0] {
        OP_NOP,  // retires without touching state.
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI, // rd = rs1 + imm.
        OP_LD,   // rd = mem[rs1 + imm].
        OP_SD    // mem[rs1 + imm] = rs2.
    } op_e;

endpackage

// File: pipe_pkg.sv
/* Stall vector layout and data memory size. */

package pipe_pkg;

    localparam int STALL_W = 5;

    // one stall bit per stage, issue at the bottom.
    localparam int ST_ISSUE = 0;
    localparam int ST_EX    = 1;
    localparam int ST_EXMEM = 2;
    localparam int ST_MEM   = 3;
    localparam int ST_WB    = 4;

    localparam int DMEM_DEPTH = 64; // doublewords.
    localparam int DMEM_AW    = 6;  // word index is address bits 8 to 3.

endpackage

// File: reg_file.sv
/* Integer register file, two combinational read ports and one write port. */

module reg_file import isa_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= ZERO_WORD;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i; // x0 stays hard-wired.
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? ZERO_WORD : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? ZERO_WORD : regs[raddr2_i];

endmodule

// File: pipe_ctrl.sv
/* Four-phase issue handshake FSM and stall vector generation. */

module pipe_ctrl import pipe_pkg::*; (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               issue_req_i,
    output logic               issue_ack_o,
    output logic               issue_take_o,
    input  logic               mem_wait_i,
    output logic [STALL_W-1:0] stall_o
);

    typedef enum logic [1:0] {
        IDLE,
        ACKED,
        RELEASE
    } state_e;

    state_e state_q;
    state_e state_d;

    // a waiting load freezes every stage and bubbles writeback.
    assign stall_o = mem_wait_i ? {STALL_W{1'b1}} : '0;

    // the payload is taken on the edge that raises ack.
    assign issue_take_o = (state_q == IDLE) && issue_req_i && !stall_o[ST_ISSUE];
    assign issue_ack_o  = (state_q == ACKED);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (issue_take_o) begin
                    state_d = ACKED;
                end
            end
            ACKED: begin
                if (!issue_req_i) begin
                    state_d = RELEASE; // ack falls on this edge.
                end
            end
            default: state_d = IDLE; // one quiet cycle after release.
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: exec_stage.sv
/* Issue-to-execute latch, operand forwarding and the ALU. */

module exec_stage import isa_pkg::*; import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [STALL_W-1:0]    stall_i,
    input  logic                  take_i,
    input  op_e                   op_i,
    input  logic [PC_W-1:0]       pc_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic [XLEN-1:0]       imm_i,
    output logic [REG_ADDR_W-1:0] rf_raddr1_o,
    output logic [REG_ADDR_W-1:0] rf_raddr2_o,
    input  logic [XLEN-1:0]       rf_rdata1_i,
    input  logic [XLEN-1:0]       rf_rdata2_i,
    input  logic                  fwd_mem_ena_i,
    input  logic [REG_ADDR_W-1:0] fwd_mem_addr_i,
    input  logic [XLEN-1:0]       fwd_mem_data_i,
    input  logic                  fwd_wb_ena_i,
    input  logic [REG_ADDR_W-1:0] fwd_wb_addr_i,
    input  logic [XLEN-1:0]       fwd_wb_data_i,
    output logic                  ex_valid_o,
    output op_e                   ex_op_o,
    output logic [PC_W-1:0]       ex_pc_o,
    output logic [REG_ADDR_W-1:0] ex_rd_o,
    output logic                  ex_rd_ena_o,
    output logic [XLEN-1:0]       ex_result_o,
    output logic [XLEN-1:0]       ex_store_data_o
);

    logic                  valid_q;
    op_e                   op_q;
    logic [PC_W-1:0]       pc_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [REG_ADDR_W-1:0] rs1_q;
    logic [REG_ADDR_W-1:0] rs2_q;
    logic [XLEN-1:0]       imm_q;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
            op_q    <= OP_NOP;
            pc_q    <= '0;
            rd_q    <= '0;
            rs1_q   <= '0;
            rs2_q   <= '0;
            imm_q   <= ZERO_WORD;
        end else if (!stall_i[ST_EX]) begin
            if (take_i) begin
                valid_q <= 1'b1;
                op_q    <= op_i;
                pc_q    <= pc_i;
                rd_q    <= rd_i;
                rs1_q   <= rs1_i;
                rs2_q   <= rs2_i;
                imm_q   <= imm_i;
            end else begin
                valid_q <= 1'b0; // nothing issued, so a bubble moves on.
                op_q    <= OP_NOP;
                rd_q    <= '0;
            end
        end
    end

    assign rf_raddr1_o = rs1_q;
    assign rf_raddr2_o = rs2_q;

    // the younger memory-stage result wins over writeback.
    function automatic logic [XLEN-1:0] resolve(input logic [REG_ADDR_W-1:0] addr,
                                                input logic [XLEN-1:0]       rf_data);
        logic [XLEN-1:0] val;
        val = rf_data;
        if (addr != '0 && fwd_mem_ena_i && fwd_mem_addr_i == addr) begin
            val = fwd_mem_data_i;
        end else if (addr != '0 && fwd_wb_ena_i && fwd_wb_addr_i == addr) begin
            val = fwd_wb_data_i;
        end
        return val;
    endfunction

    always_comb begin
        op1 = resolve(rs1_q, rf_rdata1_i);
        op2 = resolve(rs2_q, rf_rdata2_i);
        case (op_q)
            OP_ADD:  ex_result_o = op1 + op2;
            OP_SUB:  ex_result_o = op1 - op2;
            OP_AND:  ex_result_o = op1 & op2;
            OP_OR:   ex_result_o = op1 | op2;
            OP_XOR:  ex_result_o = op1 ^ op2;
            OP_ADDI, OP_LD, OP_SD: ex_result_o = op1 + imm_q; // also the memory address.
            default: ex_result_o = ZERO_WORD;
        endcase
    end

    assign ex_valid_o      = valid_q;
    assign ex_op_o         = op_q;
    assign ex_pc_o         = pc_q;
    assign ex_rd_o         = rd_q;
    assign ex_store_data_o = op2;
    assign ex_rd_ena_o     = valid_q && rd_q != '0 &&
                             (op_q inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LD});

endmodule

// File: ex_mem.sv
/* Execute-to-memory pipeline register that holds while stalled. */

module ex_mem import isa_pkg::*; import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [STALL_W-1:0]    stall_i,
    input  logic                  ex_valid_i,
    input  op_e                   ex_op_i,
    input  logic [PC_W-1:0]       ex_pc_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_i,
    input  logic                  ex_rd_ena_i,
    input  logic [XLEN-1:0]       ex_result_i,
    input  logic [XLEN-1:0]       ex_store_data_i,
    output logic                  mem_valid_o,
    output op_e                   mem_op_o,
    output logic [PC_W-1:0]       mem_pc_o,
    output logic [REG_ADDR_W-1:0] mem_rd_o,
    output logic                  mem_rd_ena_o,
    output logic [XLEN-1:0]       mem_addr_o,
    output logic [XLEN-1:0]       mem_store_data_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_valid_o      <= 1'b0;
            mem_op_o         <= OP_NOP;
            mem_pc_o         <= '0;
            mem_rd_o         <= '0;
            mem_rd_ena_o     <= 1'b0;
            mem_addr_o       <= ZERO_WORD;
            mem_store_data_o <= ZERO_WORD;
        end else if (!stall_i[ST_EXMEM]) begin
            mem_valid_o      <= ex_valid_i;
            mem_op_o         <= ex_op_i;
            mem_pc_o         <= ex_pc_i;
            mem_rd_o         <= ex_rd_i;
            mem_rd_ena_o     <= ex_rd_ena_i;
            mem_addr_o       <= ex_result_i;
            mem_store_data_o <= ex_store_data_i;
        end
    end

endmodule

// File: mem_stage.sv
/* Data memory with two-cycle loads and single-cycle stores,
   and the memory-stage result that also feeds forwarding. */

module mem_stage import isa_pkg::*; import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  mem_valid_i,
    input  op_e                   mem_op_i,
    input  logic [PC_W-1:0]       mem_pc_i,
    input  logic [REG_ADDR_W-1:0] mem_rd_i,
    input  logic                  mem_rd_ena_i,
    input  logic [XLEN-1:0]       mem_addr_i,
    input  logic [XLEN-1:0]       mem_store_data_i,
    output logic                  mem_wait_o,
    output logic                  res_valid_o,
    output logic [PC_W-1:0]       res_pc_o,
    output logic                  res_rd_ena_o,
    output logic [REG_ADDR_W-1:0] res_rd_addr_o,
    output logic [XLEN-1:0]       res_rd_data_o
);

    logic [XLEN-1:0]    dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] idx;
    logic               is_load;
    logic               phase_q;  // set in the second cycle of a load.
    logic [XLEN-1:0]    load_q;

    assign idx     = mem_addr_i[DMEM_AW+2:3];
    assign is_load = mem_valid_i && mem_op_i == OP_LD;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= ZERO_WORD;
            end
            phase_q <= 1'b0;
            load_q  <= ZERO_WORD;
        end else begin
            if (mem_valid_i && mem_op_i == OP_SD) begin
                dmem[idx] <= mem_store_data_i;
            end
            if (is_load && !phase_q) begin
                load_q <= dmem[idx]; // read now, deliver next cycle.
            end
            phase_q <= is_load && !phase_q;
        end
    end

    assign mem_wait_o = is_load && !phase_q;

    // nothing is reported until a load has its data.
    assign res_valid_o   = mem_valid_i && !mem_wait_o;
    assign res_pc_o      = mem_pc_i;
    assign res_rd_ena_o  = mem_rd_ena_i && !mem_wait_o;
    assign res_rd_addr_o = mem_rd_i;
    assign res_rd_data_o = is_load ? load_q : mem_addr_i;

endmodule

// File: mem_wb.sv
/* Memory-to-writeback register with bubble insertion,
   and the delayed commit report. */

module mem_wb import isa_pkg::*; import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [STALL_W-1:0]    stall_i,
    input  logic [PC_W-1:0]       wb_pc_i,
    input  logic                  mem_valid_i,
    input  logic [XLEN-1:0]       mem_rd_data_i,
    input  logic [REG_ADDR_W-1:0] mem_rd_addr_i,
    input  logic                  mem_rd_ena_i,
    output logic [XLEN-1:0]       wb_rd_data_o,
    output logic [REG_ADDR_W-1:0] wb_rd_addr_o,
    output logic                  wb_rd_ena_o,
    output logic                  commit_valid_o,
    output logic [PC_W-1:0]       commit_pc_o
);

    logic            wb_valid_q;
    logic [PC_W-1:0] wb_pc_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_q   <= 1'b0;
            wb_pc_q      <= '0;
            wb_rd_ena_o  <= 1'b0;
            wb_rd_addr_o <= '0;
            wb_rd_data_o <= ZERO_WORD;
        end else if (!stall_i[ST_WB]) begin
            wb_valid_q   <= mem_valid_i;
            wb_pc_q      <= wb_pc_i;
            wb_rd_ena_o  <= mem_rd_ena_i;
            wb_rd_addr_o <= mem_rd_addr_i;
            wb_rd_data_o <= mem_rd_data_i;
        end else if (&stall_i) begin
            wb_valid_q   <= 1'b0; // whole pipe frozen, insert a bubble.
            wb_pc_q      <= '0;
            wb_rd_ena_o  <= 1'b0;
            wb_rd_addr_o <= '0;
            wb_rd_data_o <= ZERO_WORD;
        end
    end

    // retirement is reported one cycle after writeback.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_valid_o <= 1'b0;
            commit_pc_o    <= '0;
        end else begin
            commit_valid_o <= wb_valid_q;
            commit_pc_o    <= wb_pc_q;
        end
    end

endmodule

// File: backend_top.sv
/* Pipeline backend top level: issue control, execute, memory,
   writeback and the register file. */

module backend_top import isa_pkg::*; import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  issue_req_i,
    output logic                  issue_ack_o,
    input  op_e                   issue_op_i,
    input  logic [PC_W-1:0]       issue_pc_i,
    input  logic [REG_ADDR_W-1:0] issue_rd_i,
    input  logic [REG_ADDR_W-1:0] issue_rs1_i,
    input  logic [REG_ADDR_W-1:0] issue_rs2_i,
    input  logic [XLEN-1:0]       issue_imm_i,
    output logic                  wb_rd_ena_o,
    output logic [REG_ADDR_W-1:0] wb_rd_addr_o,
    output logic [XLEN-1:0]       wb_rd_data_o,
    output logic                  commit_valid_o,
    output logic [PC_W-1:0]       commit_pc_o
);

    logic [STALL_W-1:0]    stall;
    logic                  issue_take;
    logic                  mem_wait;
    logic [REG_ADDR_W-1:0] rf_raddr1;
    logic [REG_ADDR_W-1:0] rf_raddr2;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;

    logic                  ex_valid;
    op_e                   ex_op;
    logic [PC_W-1:0]       ex_pc;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic                  ex_rd_ena;
    logic [XLEN-1:0]       ex_result;
    logic [XLEN-1:0]       ex_store_data;

    logic                  mem_valid;
    op_e                   mem_op;
    logic [PC_W-1:0]       mem_pc;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic                  mem_rd_ena;
    logic [XLEN-1:0]       mem_addr;
    logic [XLEN-1:0]       mem_store_data;

    logic                  res_valid;
    logic [PC_W-1:0]       res_pc;
    logic                  res_rd_ena;
    logic [REG_ADDR_W-1:0] res_rd_addr;
    logic [XLEN-1:0]       res_rd_data;

    pipe_ctrl u_pipe_ctrl (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .issue_req_i  (issue_req_i),
        .issue_ack_o  (issue_ack_o),
        .issue_take_o (issue_take),
        .mem_wait_i   (mem_wait),
        .stall_o      (stall)
    );

    exec_stage u_exec_stage (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .stall_i         (stall),
        .take_i          (issue_take),
        .op_i            (issue_op_i),
        .pc_i            (issue_pc_i),
        .rd_i            (issue_rd_i),
        .rs1_i           (issue_rs1_i),
        .rs2_i           (issue_rs2_i),
        .imm_i           (issue_imm_i),
        .rf_raddr1_o     (rf_raddr1),
        .rf_raddr2_o     (rf_raddr2),
        .rf_rdata1_i     (rf_rdata1),
        .rf_rdata2_i     (rf_rdata2),
        .fwd_mem_ena_i   (res_rd_ena),
        .fwd_mem_addr_i  (res_rd_addr),
        .fwd_mem_data_i  (res_rd_data),
        .fwd_wb_ena_i    (wb_rd_ena_o),
        .fwd_wb_addr_i   (wb_rd_addr_o),
        .fwd_wb_data_i   (wb_rd_data_o),
        .ex_valid_o      (ex_valid),
        .ex_op_o         (ex_op),
        .ex_pc_o         (ex_pc),
        .ex_rd_o         (ex_rd),
        .ex_rd_ena_o     (ex_rd_ena),
        .ex_result_o     (ex_result),
        .ex_store_data_o (ex_store_data)
    );

    ex_mem u_ex_mem (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .stall_i          (stall),
        .ex_valid_i       (ex_valid),
        .ex_op_i          (ex_op),
        .ex_pc_i          (ex_pc),
        .ex_rd_i          (ex_rd),
        .ex_rd_ena_i      (ex_rd_ena),
        .ex_result_i      (ex_result),
        .ex_store_data_i  (ex_store_data),
        .mem_valid_o      (mem_valid),
        .mem_op_o         (mem_op),
        .mem_pc_o         (mem_pc),
        .mem_rd_o         (mem_rd),
        .mem_rd_ena_o     (mem_rd_ena),
        .mem_addr_o       (mem_addr),
        .mem_store_data_o (mem_store_data)
    );

    mem_stage u_mem_stage (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .mem_valid_i      (mem_valid),
        .mem_op_i         (mem_op),
        .mem_pc_i         (mem_pc),
        .mem_rd_i         (mem_rd),
        .mem_rd_ena_i     (mem_rd_ena),
        .mem_addr_i       (mem_addr),
        .mem_store_data_i (mem_store_data),
        .mem_wait_o       (mem_wait),
        .res_valid_o      (res_valid),
        .res_pc_o         (res_pc),
        .res_rd_ena_o     (res_rd_ena),
        .res_rd_addr_o    (res_rd_addr),
        .res_rd_data_o    (res_rd_data)
    );

    mem_wb u_mem_wb (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .stall_i        (stall),
        .wb_pc_i        (res_pc),
        .mem_valid_i    (res_valid),
        .mem_rd_data_i  (res_rd_data),
        .mem_rd_addr_i  (res_rd_addr),
        .mem_rd_ena_i   (res_rd_ena),
        .wb_rd_data_o   (wb_rd_data_o),
        .wb_rd_addr_o   (wb_rd_addr_o),
        .wb_rd_ena_o    (wb_rd_ena_o),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (wb_rd_ena_o),
        .waddr_i  (wb_rd_addr_o),
        .wdata_i  (wb_rd_data_o),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

endmodule

// File: tb_backend.sv
/* Testbench for the pipeline backend: clock and reset, a table of operations
   issued over the four-phase port, a reference model and commit checks. */

module tb_backend import isa_pkg::*; import pipe_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACK_TIMEOUT   = 20;  // cycles allowed for each ack edge.
    localparam int DRAIN_TIMEOUT = 50;

    typedef struct packed {
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
    } entry_t;

    typedef struct packed {
        logic [PC_W-1:0]       pc;
        logic                  ena;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } expect_t;

    logic                  clk;
    logic                  arst_n;
    logic                  issue_req;
    logic                  issue_ack;
    op_e                   issue_op;
    logic [PC_W-1:0]       issue_pc;
    logic [REG_ADDR_W-1:0] issue_rd;
    logic [REG_ADDR_W-1:0] issue_rs1;
    logic [REG_ADDR_W-1:0] issue_rs2;
    logic [XLEN-1:0]       issue_imm;
    logic                  wb_rd_ena;
    logic [REG_ADDR_W-1:0] wb_rd_addr;
    logic [XLEN-1:0]       wb_rd_data;
    logic                  commit_valid;
    logic [PC_W-1:0]       commit_pc;

    entry_t                entries[$];
    expect_t               exp_q[$];    // one entry per issued operation, in order.
    logic [XLEN-1:0]       shadow_regs [NUM_REGS];
    logic [XLEN-1:0]       shadow_mem [DMEM_DEPTH];
    logic [63:0]           rng_state = 64'd38;
    int                    errors;
    int                    timeouts;
    int                    commits;
    bit                    issued_any;
    logic                  prev_ena;
    logic [REG_ADDR_W-1:0] prev_addr;
    logic [XLEN-1:0]       prev_data;

    backend_top dut (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .issue_req_i    (issue_req),
        .issue_ack_o    (issue_ack),
        .issue_op_i     (issue_op),
        .issue_pc_i     (issue_pc),
        .issue_rd_i     (issue_rd),
        .issue_rs1_i    (issue_rs1),
        .issue_rs2_i    (issue_rs2),
        .issue_imm_i    (issue_imm),
        .wb_rd_ena_o    (wb_rd_ena),
        .wb_rd_addr_o   (wb_rd_addr),
        .wb_rd_data_o   (wb_rd_data),
        .commit_valid_o (commit_valid),
        .commit_pc_o    (commit_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [63:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    function automatic void add_entry(input op_e op, input int rd, input int rs1, input int rs2,
                                      input logic [XLEN-1:0] imm, input bit rnd);
        entry_t e;
        e.op  = op;
        e.rd  = REG_ADDR_W'(rd);
        e.rs1 = REG_ADDR_W'(rs1);
        e.rs2 = REG_ADDR_W'(rs2);
        e.imm = rnd ? next_rand() : imm;
        entries.push_back(e);
    endfunction

    // the pc of an entry is its index times four.
    function automatic void build_table();
        add_entry(OP_ADDI, 1, 0, 0, 64'd5, 1'b0);
        add_entry(OP_ADDI, 2, 1, 0, '0, 1'b1);
        add_entry(OP_ADD, 3, 1, 2, '0, 1'b0);   // chain of dependent ALU ops.
        add_entry(OP_SUB, 4, 3, 1, '0, 1'b0);
        add_entry(OP_AND, 5, 4, 2, '0, 1'b0);
        add_entry(OP_OR, 6, 5, 3, '0, 1'b0);
        add_entry(OP_XOR, 7, 6, 4, '0, 1'b0);
        add_entry(OP_ADDI, 8, 0, 0, 64'h40, 1'b0);
        add_entry(OP_SD, 3, 8, 7, 64'd8, 1'b0);  // a nonzero rd field must not write.
        add_entry(OP_LD, 9, 8, 0, 64'd8, 1'b0);
        add_entry(OP_ADD, 10, 9, 1, '0, 1'b0);   // load result used right away.
        add_entry(OP_ADDI, 0, 1, 0, 64'd77, 1'b0);
        add_entry(OP_ADD, 11, 0, 0, '0, 1'b0);
        add_entry(OP_OR, 12, 0, 1, '0, 1'b0);
        add_entry(OP_LD, 13, 8, 0, '0, 1'b0);
        add_entry(OP_ADDI, 14, 13, 0, '0, 1'b1);
        add_entry(OP_SD, 0, 2, 14, '0, 1'b0);
        add_entry(OP_NOP, 0, 0, 0, '0, 1'b0);
        add_entry(OP_LD, 15, 2, 0, '0, 1'b0);
        add_entry(OP_XOR, 16, 15, 14, '0, 1'b0);
        add_entry(OP_LD, 17, 8, 0, 64'd8, 1'b0);
        add_entry(OP_SUB, 18, 17, 10, '0, 1'b0);
        add_entry(OP_ADDI, 19, 18, 0, '0, 1'b1);
        add_entry(OP_NOP, 0, 0, 0, '0, 1'b0);
    endfunction

    // executes one entry on the shadow state and queues its expected retirement.
    function automatic void run_model(input entry_t e, input int idx);
        expect_t            x;
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    b;
        logic [XLEN-1:0]    v;
        logic [XLEN-1:0]    addr;
        logic [DMEM_AW-1:0] w;
        a    = shadow_regs[e.rs1];
        b    = shadow_regs[e.rs2];
        v    = ZERO_WORD;
        addr = a + e.imm;
        w    = addr[8:3];  // doubleword index, upper bits ignored.
        case (e.op)
            OP_ADD:  v = a + b;
            OP_SUB:  v = a - b;
            OP_AND:  v = a & b;
            OP_OR:   v = a | b;
            OP_XOR:  v = a ^ b;
            OP_ADDI: v = addr;
            OP_LD:   v = shadow_mem[w];
            OP_SD:   shadow_mem[w] = b;
            default: v = ZERO_WORD;
        endcase
        x.pc   = PC_W'(idx * 4);
        x.ena  = (e.rd != '0) && !(e.op inside {OP_NOP, OP_SD});
        x.addr = e.rd;
        x.data = v;
        if (x.ena) begin
            shadow_regs[e.rd] = v;
        end
        exp_q.push_back(x);
    endfunction

    function automatic void check_value(input string name, input logic [63:0] got,
                                        input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s: got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endfunction

    task automatic wait_ack(input logic level, output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            if (issue_ack === level) begin
                ok = 1'b1;
            end
            cycles++;
        end
        if (!ok) begin
            $display("timeout: issue_ack_o did not go to %0b within %0d cycles", level,
                     ACK_TIMEOUT);
        end
    endtask

    // one full four-phase transfer of a table entry.
    task automatic issue_entry(input entry_t e, input int idx, output bit ok);
        @(posedge clk);
        issue_req  <= 1'b1;
        issue_op   <= e.op;
        issue_pc   <= PC_W'(idx * 4);
        issue_rd   <= e.rd;
        issue_rs1  <= e.rs1;
        issue_rs2  <= e.rs2;
        issue_imm  <= e.imm;
        issued_any = 1'b1;
        wait_ack(1'b1, ok);
        if (ok) begin
            @(posedge clk);
            issue_req <= 1'b0;
            wait_ack(1'b0, ok);
        end
    endtask

    // a commit reports the write-back seen one cycle earlier.
    always @(negedge clk) begin : monitor
        expect_t x;
        if (arst_n === 1'b1) begin
            if (!issued_any) begin
                assert (issue_ack === 1'b0 && wb_rd_ena === 1'b0 && commit_valid === 1'b0)
                else begin
                    $display("ack, write-back or commit went high before the first issue");
                    errors++;
                end
            end
            if (commit_valid === 1'b1) begin
                commits++;
                assert (exp_q.size() > 0) else begin
                    $display("a commit appeared at %0t ns with nothing outstanding", $time);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    x = exp_q.pop_front();
                    check_value("commit_pc_o", commit_pc, x.pc);
                    check_value("wb_rd_ena_o", 64'(prev_ena), 64'(x.ena));
                    if (x.ena) begin
                        check_value("wb_rd_addr_o", 64'(prev_addr), 64'(x.addr));
                        check_value("wb_rd_data_o", prev_data, x.data);
                    end
                end
            end else begin
                assert (prev_ena !== 1'b1) else begin
                    $display("a write-back at %0t ns was not followed by a commit", $time);
                    errors++;
                end
            end
        end
        prev_ena  = wb_rd_ena;
        prev_addr = wb_rd_addr;
        prev_data = wb_rd_data;
    end

    initial begin : stimulus
        bit ok;
        int cycles;
        issue_req  = 1'b0;
        issue_op   = OP_NOP;
        issue_pc   = '0;
        issue_rd   = '0;
        issue_rs1  = '0;
        issue_rs2  = '0;
        issue_imm  = '0;
        arst_n     = 1'b0;
        errors     = 0;
        timeouts   = 0;
        commits    = 0;
        issued_any = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow_regs[i] = ZERO_WORD;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            shadow_mem[i] = ZERO_WORD;
        end
        build_table();
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        repeat (3) @(posedge clk);  // idle cycles for the reset check.
        for (int i = 0; i < entries.size(); i++) begin
            run_model(entries[i], i);
            issue_entry(entries[i], i, ok);
            if (!ok) begin
                timeouts++;
                break;
            end
        end
        if (timeouts == 0) begin
            cycles = 0;
            while (exp_q.size() > 0 && cycles < DRAIN_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (exp_q.size() > 0) begin
                $display("timeout: %0d operations never committed", exp_q.size());
                timeouts++;
            end
            repeat (4) @(negedge clk);  // catch any stray late commit.
        end
        assert (commits == entries.size()) else begin
            $display("saw %0d commits for %0d issued operations", commits, entries.size());
            errors++;
        end
        $display("errors %0d, timeouts %0d, commits %0d of %0d", errors, timeouts, commits,
                 entries.size());
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
isa_pkg.sv
pipe_pkg.sv
reg_file.sv
pipe_ctrl.sv
exec_stage.sv
ex_mem.sv
mem_stage.sv
mem_wb.sv
backend_top.sv
tb_backend.sv

// File: Bender.yml
package:
  name: pipe_backend

sources:
  - isa_pkg.sv
  - pipe_pkg.sv
  - reg_file.sv
  - pipe_ctrl.sv
  - exec_stage.sv
  - ex_mem.sv
  - mem_stage.sv
  - mem_wb.sv
  - backend_top.sv
  - target: test
    files:
      - tb_backend.sv
